// File: rtl/modexp_pkg.sv
package modexp_pkg;

	////////////////////////////////////////////////////////////////////////////
	// Register map

	// APB address width
	localparam int ADDR_WIDTH = 12;

	// Exponent block, 8 words, word i holds bits 32i+31 down to 32i
	localparam logic [ADDR_WIDTH-1:0] REG_E        = 12'h000;
	// Bit 0 is busy
	localparam logic [ADDR_WIDTH-1:0] REG_STATUS   = 12'h020;
	// Command register
	localparam logic [ADDR_WIDTH-1:0] REG_CMD      = 12'h028;
	// Second copy of status
	localparam logic [ADDR_WIDTH-1:0] REG_STATUS_2 = 12'h040;
	// Base value, word 0 only
	localparam logic [ADDR_WIDTH-1:0] REG_WORK     = 12'h060;
	// Result readback, word 0 only
	localparam logic [ADDR_WIDTH-1:0] REG_DATA_OUT = 12'h140;
	// Last decoded byte address
	localparam logic [ADDR_WIDTH-1:0] REG_LAST     = 12'h15F;

	// Block indexes from address bits 8 to 5
	localparam logic [3:0] BLOCK_E        = REG_E[8:5];
	localparam logic [3:0] BLOCK_WORK     = REG_WORK[8:5];
	localparam logic [3:0] BLOCK_DATA_OUT = REG_DATA_OUT[8:5];

	////////////////////////////////////////////////////////////////////////////
	// Field and exponent

	// Field element width
	localparam int FIELD_BITS = 31;
	// Mersenne prime 2^31-1
	localparam logic [FIELD_BITS-1:0] FIELD_P = 31'h7FFF_FFFF;
	// Exponent width in bits
	localparam int EXP_BITS = 256;

	////////////////////////////////////////////////////////////////////////////
	// Commands and FSM states

	typedef enum logic [7:0] {
		CMD_NOP    = 8'h00,
		CMD_MODEXP = 8'h01
	} cmd_t;

	typedef enum logic [2:0] {
		ST_IDLE,
		ST_LOAD,
		ST_MUL,
		ST_SQR,
		ST_DONE
	} state_t;

endpackage

// File: rtl/mersenne_mul.sv
`timescale 1ns/1ps

module mersenne_mul import modexp_pkg::*; (
	input  logic [FIELD_BITS-1:0] a,
	input  logic [FIELD_BITS-1:0] b,
	output logic [FIELD_BITS-1:0] p
);

	// Full product
	logic [2*FIELD_BITS-1:0] prod;
	// First fold, fits in 32 bits
	logic [FIELD_BITS:0]     fold1;
	// Second fold, at most FIELD_P
	logic [FIELD_BITS-1:0]   fold2;

	assign prod = a * b;

	// 2^31 == 1 mod p, so high half adds onto low half
	assign fold1 = {1'b0, prod[FIELD_BITS-1:0]} + {1'b0, prod[2*FIELD_BITS-1:FIELD_BITS]};

	// Carry out of the first fold wraps in as a one
	assign fold2 = fold1[FIELD_BITS-1:0] + FIELD_BITS'(fold1[FIELD_BITS]);

	// p itself is zero in the field
	assign p = (fold2 == FIELD_P) ? '0 : fold2;

	// Canonical residue of the full product
	always_comb begin
		if (!$isunknown({a, b}))
			assert (64'(p) == (64'(a) * 64'(b)) % 64'(FIELD_P));
	end

endmodule

// File: rtl/bit_counter.sv
`timescale 1ns/1ps

module bit_counter import modexp_pkg::*; (
	input  logic       apb,
	input  logic       rst,
	input  logic       load,
	input  logic       step_sqr,
	output logic [7:0] bit_index,
	output logic       last
);

	// Top exponent bit
	localparam logic [7:0] TOP_BIT = 8'(EXP_BITS - 1);

	always_ff @(posedge apb) begin
		if (rst) begin
			bit_index <= 8'd0;
		end else if (load) begin
			bit_index <= TOP_BIT;
		end else if (step_sqr && !last) begin
			// One bit done per square step
			bit_index <= bit_index - 8'd1;
		end
	end

	// Final bit of the walk
	assign last = (bit_index == 8'd0);

	// Square at bit 0 is the final one, index holds until reload
	assert property (@(posedge apb) disable iff (rst)
		(step_sqr && last && !load) |=> (!step_sqr && last));

endmodule

// File: rtl/ladder_fsm.sv
`timescale 1ns/1ps

module ladder_fsm import modexp_pkg::*; (
	input  logic apb,
	input  logic rst,
	input  logic start,
	input  logic last,
	output logic load,
	output logic step_mul,
	output logic step_sqr,
	output logic done,
	output logic busy
);

	state_t state;
	state_t state_nxt;

	////////////////////////////////////////////////////////////////////////////
	// Next state

	always_comb begin
		state_nxt = state;
		case (state)
			// Start while busy never reaches here
			ST_IDLE: if (start) state_nxt = ST_LOAD;
			ST_LOAD: state_nxt = ST_MUL;
			ST_MUL:  state_nxt = ST_SQR;
			// Bit 0 just consumed ends the ladder
			ST_SQR:  state_nxt = last ? ST_DONE : ST_MUL;
			ST_DONE: state_nxt = ST_IDLE;
			default: state_nxt = ST_IDLE;
		endcase
	end

	always_ff @(posedge apb) begin
		if (rst)
			state <= ST_IDLE;
		else
			state <= state_nxt;
	end

	// Step strobes decoded from state
	assign load     = (state == ST_LOAD);
	assign step_mul = (state == ST_MUL);
	assign step_sqr = (state == ST_SQR);
	assign done     = (state == ST_DONE);
	assign busy     = (state != ST_IDLE);

	// Counter leaves bit 0 after a load
	assert property (@(posedge apb) disable iff (rst)
		load |=> !last);

	// Start arrives as a single-cycle pulse
	assert property (@(posedge apb) disable iff (rst)
		start |=> !start);

endmodule

// File: rtl/ladder_state.sv
`timescale 1ns/1ps

module ladder_state import modexp_pkg::*; (
	input  logic                  apb,
	input  logic                  rst,
	input  logic                  load,
	input  logic                  step_mul,
	input  logic                  step_sqr,
	input  logic                  done,
	input  logic [EXP_BITS-1:0]   e,
	input  logic [7:0]            bit_index,
	input  logic [31:0]           work,
	input  logic [FIELD_BITS-1:0] prod,
	output logic [FIELD_BITS-1:0] mul_a,
	output logic [FIELD_BITS-1:0] mul_b,
	output logic [FIELD_BITS-1:0] result
);

	logic [FIELD_BITS-1:0] r0;
	logic [FIELD_BITS-1:0] r1;
	logic                  cur_bit;
	// Base folded once, may still equal p
	logic [31:0]           work_fold;
	logic [FIELD_BITS-1:0] work_red;

	assign cur_bit = e[bit_index];

	////////////////////////////////////////////////////////////////////////////
	// Base reduction

	assign work_fold = {1'b0, work[30:0]} + 32'(work[31]);
	assign work_red  = (work_fold >= {1'b0, FIELD_P}) ?
		FIELD_BITS'(work_fold - {1'b0, FIELD_P}) : work_fold[FIELD_BITS-1:0];

	////////////////////////////////////////////////////////////////////////////
	// Operand select

	// MUL always takes R0*R1
	// SQR squares R1 on a one bit, R0 otherwise
	assign mul_a = (step_sqr && cur_bit) ? r1 : r0;
	assign mul_b = step_sqr ? (cur_bit ? r1 : r0) : r1;

	// Ladder registers
	always_ff @(posedge apb) begin
		if (load) begin
			r0 <= FIELD_BITS'(1);
			r1 <= work_red;
		end else if (step_mul) begin
			if (cur_bit)
				r0 <= prod;
			else
				r1 <= prod;
		end else if (step_sqr) begin
			if (cur_bit)
				r1 <= prod;
			else
				r0 <= prod;
		end
	end

	// Result holds the last finished run
	always_ff @(posedge apb) begin
		if (rst)
			result <= '0;
		else if (done)
			result <= r0;
	end

endmodule

// File: rtl/apb_modexp_regs.sv
`timescale 1ns/1ps

module apb_modexp_regs import modexp_pkg::*; (
	input  logic                  apb,
	input  logic                  rst,
	input  logic                  psel,
	input  logic                  penable,
	input  logic                  pwrite,
	input  logic [ADDR_WIDTH-1:0] paddr,
	input  logic [31:0]           pwdata,
	input  logic                  busy,
	input  logic [FIELD_BITS-1:0] result,
	output logic [31:0]           prdata,
	output logic                  pready,
	output logic                  pslverr,
	output logic                  start,
	output logic [EXP_BITS-1:0]   e,
	output logic [31:0]           work
);

	////////////////////////////////////////////////////////////////////////////
	// Address decode

	// Word within a 32-byte block
	logic [2:0] word_idx;
	// Block selected by address bits 8 to 5
	logic [3:0] block_idx;
	logic       in_range;
	logic       wr_acc;
	logic       status_hit;

	assign word_idx   = paddr[4:2];
	assign block_idx  = paddr[8:5];
	assign in_range   = (paddr <= REG_LAST);
	assign status_hit = (paddr == REG_STATUS) || (paddr == REG_STATUS_2);

	// No wait states
	assign pready = psel && penable;
	assign wr_acc = pready && pwrite && in_range;

	////////////////////////////////////////////////////////////////////////////
	// Readback and error response

	always_comb begin
		prdata  = 32'h0;
		pslverr = 1'b0;
		if (pready) begin
			if (pwrite) begin
				// Writes past the map are refused
				if (!in_range)
					pslverr = 1'b1;
			end else begin
				if (status_hit)
					prdata = {31'h0, busy};
				// Only word 0 of the result block is readable
				else if (in_range && block_idx == BLOCK_DATA_OUT && word_idx == 3'd0)
					prdata = {1'b0, result};
				else
					pslverr = 1'b1;
			end
		end
	end

	////////////////////////////////////////////////////////////////////////////
	// Command decode

	// Start pulse one cycle after the command write
	always_ff @(posedge apb) begin
		if (rst) begin
			start <= 1'b0;
		end else begin
			start <= 1'b0;
			if (wr_acc && paddr == REG_CMD && pwdata[31:8] == 24'h0) begin
				case (cmd_t'(pwdata[7:0]))
					CMD_MODEXP: start <= 1'b1;
					CMD_NOP: begin
					end
					// Unknown opcodes are dropped
					default: begin
					end
				endcase
			end
		end
	end

	// Operand registers, words land in any order
	always_ff @(posedge apb) begin
		if (wr_acc) begin
			case (block_idx)
				BLOCK_E: e[32*word_idx +: 32] <= pwdata;
				BLOCK_WORK: begin
					// Base is a single word
					if (word_idx == 3'd0)
						work <= pwdata;
				end
				default: begin
				end
			endcase
		end
	end

	// Access phase must follow a setup phase with psel held
	assert property (@(posedge apb) disable iff (rst)
		$rose(pready) |-> $past(psel));

endmodule

// File: rtl/modexp_top.sv
`timescale 1ns/1ps

module modexp_top import modexp_pkg::*; (
	input  logic                  apb,
	input  logic                  rst,
	input  logic                  psel,
	input  logic                  penable,
	input  logic                  pwrite,
	input  logic [ADDR_WIDTH-1:0] paddr,
	input  logic [31:0]           pwdata,
	output logic [31:0]           prdata,
	output logic                  pready,
	output logic                  pslverr
);

	// Control strobes
	logic                  start;
	logic                  load;
	logic                  step_mul;
	logic                  step_sqr;
	logic                  done;
	logic                  busy;
	logic                  last;
	logic [7:0]            bit_index;
	// Operands and results
	logic [EXP_BITS-1:0]   e;
	logic [31:0]           work;
	logic [FIELD_BITS-1:0] mul_a;
	logic [FIELD_BITS-1:0] mul_b;
	logic [FIELD_BITS-1:0] prod;
	logic [FIELD_BITS-1:0] result;

	////////////////////////////////////////////////////////////////////////////
	// Bus side

	apb_modexp_regs u_regs (
		.apb(apb), .rst(rst),
		.psel(psel), .penable(penable), .pwrite(pwrite),
		.paddr(paddr), .pwdata(pwdata),
		.busy(busy), .result(result),
		.prdata(prdata), .pready(pready), .pslverr(pslverr),
		.start(start), .e(e), .work(work)
	);

	////////////////////////////////////////////////////////////////////////////
	// Ladder engine

	ladder_fsm u_fsm (
		.apb(apb), .rst(rst), .start(start), .last(last),
		.load(load), .step_mul(step_mul), .step_sqr(step_sqr),
		.done(done), .busy(busy)
	);

	bit_counter u_cnt (
		.apb(apb), .rst(rst), .load(load), .step_sqr(step_sqr),
		.bit_index(bit_index), .last(last)
	);

	ladder_state u_state (
		.apb(apb), .rst(rst), .load(load), .step_mul(step_mul),
		.step_sqr(step_sqr), .done(done), .e(e), .bit_index(bit_index),
		.work(work), .prod(prod),
		.mul_a(mul_a), .mul_b(mul_b), .result(result)
	);

	// Single shared multiplier
	mersenne_mul u_mul (
		.a(mul_a), .b(mul_b), .p(prod)
	);

endmodule

// File: tests/tb_modexp.sv
`timescale 1ns/1ps

module tb_modexp import modexp_pkg::*; ();

	logic                  apb;
	logic                  rst;
	logic                  psel;
	logic                  penable;
	logic                  pwrite;
	logic [ADDR_WIDTH-1:0] paddr;
	logic [31:0]           pwdata;
	logic [31:0]           prdata;
	logic                  pready;
	logic                  pslverr;

	// Word 0 is the count, then 10 words per vector
	logic [31:0] vec_mem [0:320];
	int          vec_count;
	int          errors;
	int          checks;
	int          tests;
	int          failed;
	int          cycles;
	int          limit;
	logic [15:0] lfsr;

	modexp_top DUT (
		.apb(apb), .rst(rst), .psel(psel), .penable(penable), .pwrite(pwrite),
		.paddr(paddr), .pwdata(pwdata), .prdata(prdata), .pready(pready), .pslverr(pslverr)
	);

	initial begin
		apb = 1'b0;
		forever #20 apb = ~apb;
	end

	// Watchdog sized from the vector count
	always @(posedge apb) begin
		cycles++;
		if (limit > 0 && cycles >= limit) begin
			$display("timeout after %0d cycles, the engine never went idle", cycles);
			$display("TEST FAIL");
			$finish;
		end
	end

	////////////////////////////////////////////////////////////////////////////
	// Helpers

	task automatic check(input string name, input logic [31:0] got, input logic [31:0] exp);
		checks++;
		if (got !== exp) begin
			errors++;
			$display("mismatch at %0d ns: %s got %08h expected %08h", $time, name, got, exp);
		end
	endtask

	// Galois form, taps 16,14,13,11
	function automatic logic [15:0] lfsr_next(input logic [15:0] s);
		return s[0] ? ((s >> 1) ^ 16'hB400) : (s >> 1);
	endfunction

	// One LFSR step per bit
	function automatic logic [2:0] pick3();
		logic [2:0] v;
		for (int i = 0; i < 3; i++) begin
			v[i] = lfsr[0];
			lfsr = lfsr_next(lfsr);
		end
		return v;
	endfunction

	function automatic logic [31:0] vec_word(input int v, input int k);
		return vec_mem[1 + v * 10 + k];
	endfunction

	// Setup cycle, access cycle, sample mid-cycle
	task automatic apb_xfer(input logic wr, input logic [ADDR_WIDTH-1:0] addr,
		input logic [31:0] data, output logic [31:0] rdata, output logic err);
		@(posedge apb);
		#2;
		psel    = 1'b1;
		penable = 1'b0;
		pwrite  = wr;
		paddr   = addr;
		pwdata  = data;
		@(negedge apb);
		// Setup phase never completes
		check("pready", {31'h0, pready}, 32'h0);
		@(posedge apb);
		#2;
		penable = 1'b1;
		@(negedge apb);
		while (!pready)
			@(negedge apb);
		rdata = prdata;
		err   = pslverr;
		@(posedge apb);
		#2;
		psel    = 1'b0;
		penable = 1'b0;
	endtask

	// Access expected to complete without error
	task automatic access_ok(input logic wr, input logic [ADDR_WIDTH-1:0] addr,
		input logic [31:0] data, output logic [31:0] rdata);
		logic err;
		apb_xfer(wr, addr, data, rdata, err);
		check("pslverr", {31'h0, err}, 32'h0);
	endtask

	// E words in LFSR order, then the base
	task automatic load_vector(input int v);
		logic [7:0]  used;
		logic [2:0]  k;
		logic [31:0] rd;
		used = 8'h0;
		for (int i = 0; i < 8; i++) begin
			k = pick3();
			// Taken slot, step to the next free word
			while (used[k])
				k = k + 3'd1;
			used[k] = 1'b1;
			access_ok(1'b1, REG_E + {7'h0, k, 2'b00}, vec_word(v, int'(k)), rd);
		end
		access_ok(1'b1, REG_WORK, vec_word(v, 8), rd);
	endtask

	// Command, then busy on the first poll of both copies
	task automatic start_run();
		logic [31:0] st;
		access_ok(1'b1, REG_CMD, {24'h0, CMD_MODEXP}, st);
		access_ok(1'b0, REG_STATUS, 32'h0, st);
		check("status", st, 32'h1);
		access_ok(1'b0, REG_STATUS_2, 32'h0, st);
		check("status_2", st, 32'h1);
	endtask

	task automatic wait_idle();
		logic [31:0] st;
		st = 32'h1;
		while (st[0])
			access_ok(1'b0, REG_STATUS, 32'h0, st);
		access_ok(1'b0, REG_STATUS_2, 32'h0, st);
		check("status_2", st, 32'h0);
	endtask

	task automatic finish_test(input string name, input int mark);
		tests++;
		if (errors == mark) begin
			$display("%s: ok", name);
		end else begin
			failed++;
			$display("%s: failed, %0d errors", name, errors - mark);
		end
	endtask

	////////////////////////////////////////////////////////////////////////////
	// Sequence

	initial begin
		logic [31:0]           rd;
		logic                  err;
		int                    mark;
		int                    t0;
		logic [ADDR_WIDTH-1:0] bad [4];
		rst     = 1'b1;
		psel    = 1'b0;
		penable = 1'b0;
		pwrite  = 1'b0;
		paddr   = '0;
		pwdata  = 32'h0;
		{errors, checks, tests, failed, cycles} = '0;
		lfsr = 16'd72;
		$readmemh("tests/modexp_tests.mem", vec_mem);
		vec_count = int'(vec_mem[0]);
		if (vec_count < 1 || vec_count > 32) begin
			$display("vector file gives no usable vector count");
			errors++;
			vec_count = 0;
		end
		limit = vec_count * 600 + 2000;
		repeat (4) @(posedge apb);
		#2;
		rst = 1'b0;

		// Full runs against file results
		for (int v = 0; v < vec_count; v++) begin
			mark = errors;
			load_vector(v);
			start_run();
			wait_idle();
			access_ok(1'b0, REG_DATA_OUT, 32'h0, rd);
			check("data_out", rd, vec_word(v, 9));
			finish_test($sformatf("vector %0d", v), mark);
		end

		// NOP and unknown opcode never start
		mark = errors;
		access_ok(1'b1, REG_CMD, {24'h0, CMD_NOP}, rd);
		access_ok(1'b0, REG_STATUS, 32'h0, rd);
		check("status", rd, 32'h0);
		access_ok(1'b1, REG_CMD, 32'h5, rd);
		access_ok(1'b0, REG_STATUS, 32'h0, rd);
		check("status", rd, 32'h0);
		access_ok(1'b0, REG_DATA_OUT, 32'h0, rd);
		check("data_out", rd, vec_word(vec_count - 1, 9));
		finish_test("ignored commands", mark);

		// Unreadable words and a write past the map
		mark = errors;
		bad = '{REG_E + 12'h4, REG_WORK, REG_CMD, REG_DATA_OUT + 12'h4};
		for (int i = 0; i < 4; i++) begin
			apb_xfer(1'b0, bad[i], 32'h0, rd, err);
			check("pslverr", {31'h0, err}, 32'h1);
			check("prdata", rd, 32'h0);
		end
		apb_xfer(1'b1, 12'h160, 32'h1234, rd, err);
		check("pslverr", {31'h0, err}, 32'h1);
		finish_test("slave errors", mark);

		// Second command mid-run, old result held until idle
		mark = errors;
		load_vector(0);
		t0 = cycles;
		start_run();
		access_ok(1'b0, REG_DATA_OUT, 32'h0, rd);
		check("data_out", rd, vec_word(vec_count - 1, 9));
		access_ok(1'b1, REG_CMD, {24'h0, CMD_MODEXP}, rd);
		access_ok(1'b0, REG_DATA_OUT, 32'h0, rd);
		check("data_out", rd, vec_word(vec_count - 1, 9));
		wait_idle();
		// Command access, start cycle, 514 busy cycles, one poll and the status_2 read
		if (cycles - t0 > 3 + 1 + 514 + 6) begin
			$display("command while busy restarted the run, idle only after %0d cycles",
				cycles - t0);
			errors++;
		end
		access_ok(1'b0, REG_DATA_OUT, 32'h0, rd);
		check("data_out", rd, vec_word(0, 9));
		finish_test("command while busy", mark);

		$display("tests %0d, failed %0d, checks %0d, errors %0d", tests, failed, checks, errors);
		if (errors == 0)
			$display("TEST PASS");
		else
			$display("TEST FAIL");
		$finish;
	end

endmodule

// File: tests/modexp_tests.mem
// First word: vector count. Then one vector per line:
// e0 e1 e2 e3 e4 e5 e6 e7 (exponent, low word first) base expected
00000011
00000001 00000000 00000000 00000000 00000000 00000000 00000000 00000000 00000002 00000002
0000001F 00000000 00000000 00000000 00000000 00000000 00000000 00000000 00000002 00000001
0000001E 00000000 00000000 00000000 00000000 00000000 00000000 00000000 00000002 40000000
00000002 00000000 00000000 00000000 00000000 00000000 00000000 00000000 80000002 00000009
00000000 00000001 00000000 00000000 00000000 00000000 00000000 00000000 00000002 00000010
00000000 00000000 00000001 00000000 00000000 00000000 00000000 00000000 00000002 00010000
00000000 00000000 00000000 00000000 00000000 00000000 00000000 80000000 00000002 00000002
FFFFFFFF FFFFFFFF FFFFFFFF FFFFFFFF FFFFFFFF FFFFFFFF FFFFFFFF FFFFFFFF 00000002 00000002
00000003 00000000 00000000 00000000 00000000 00000000 00000000 00000000 7FFFFFFE 7FFFFFFE
00000000 00000001 00000000 00000000 00000000 00000000 00000000 00000000 7FFFFFFE 00000001
00000005 00000000 00000000 00000000 00000000 00000000 00000000 00000000 FFFFFFFF 00000001
00000002 00000000 00000000 00000000 00000000 00000000 00000000 00000000 0000B505 0000121A
00000003 00000000 00000000 00000000 00000000 00000000 00000000 00000000 40000000 10000000
00000001 00000000 00000000 00000005 00000000 00000000 00000000 00000000 00000002 00000800
00000000 00000000 00000000 00000000 00000000 00000000 00000000 00000000 00000005 00000001
00000001 00000000 00000000 00000000 00000000 00000000 00000000 00000000 7FFFFFFF 00000000
00000003 00000000 00000000 00000000 00000000 00000000 00000000 00000000 00000007 00000157

// File: vlog.f
rtl/modexp_pkg.sv
rtl/mersenne_mul.sv
rtl/bit_counter.sv
rtl/ladder_fsm.sv
rtl/ladder_state.sv
rtl/apb_modexp_regs.sv
rtl/modexp_top.sv
tests/tb_modexp.sv

// File: Makefile
TOOL     = verilator
FLAGS    = --binary --timing --assert -Wno-fatal
TOP      = tb_modexp
FILELIST = vlog.f
LOG      = sim.log
EXE      = obj_dir/V$(TOP)

.PHONY: all compile run clean

all: run

compile:
	$(TOOL) $(FLAGS) --top-module $(TOP) -f $(FILELIST)

run: compile
	./$(EXE) > $(LOG) 2>&1; cat $(LOG)
	grep -q "TEST PASS" $(LOG)

clean:
	rm -rf obj_dir $(LOG)
